// File: hw/mipsPkg.sv
// Shared widths, opcode and funct codes, ALU selectors
// Instruction union, control word, memory request and retire structs
`default_nettype none

package mipsPkg;

	//////////////////////////////////////////////////////////////////////
	// Widths and sizes
	//////////////////////////////////////////////////////////////////////
	localparam int dataWidth    = 32;                  // Data word
	localparam int regAddrWidth = 5;                   // Register index
	localparam int memAddrWidth = 9;                   // Byte address
	localparam int memBytes     = 512;                 // Data memory size

	//////////////////////////////////////////////////////////////////////
	// Opcodes
	//////////////////////////////////////////////////////////////////////
	localparam logic [5:0] opR     = 6'b000000;        // Register format
	localparam logic [5:0] opAddi  = 6'b001000;
	localparam logic [5:0] opAddiu = 6'b001001;
	localparam logic [5:0] opSlti  = 6'b001010;
	localparam logic [5:0] opSltiu = 6'b001011;
	localparam logic [5:0] opAndi  = 6'b001100;
	localparam logic [5:0] opOri   = 6'b001101;
	localparam logic [5:0] opXori  = 6'b001110;
	localparam logic [5:0] opLui   = 6'b001111;
	localparam logic [5:0] opLw    = 6'b100011;        // Word load
	localparam logic [5:0] opSw    = 6'b101011;        // Word store

	//////////////////////////////////////////////////////////////////////
	// Funct codes, also used as the ALU operation code
	//////////////////////////////////////////////////////////////////////
	localparam logic [5:0] fnAdd  = 6'b100000;
	localparam logic [5:0] fnClo  = 6'b100001;         // Count leading ones
	localparam logic [5:0] fnSub  = 6'b100010;
	localparam logic [5:0] fnAnd  = 6'b100100;
	localparam logic [5:0] fnOr   = 6'b100101;
	localparam logic [5:0] fnXor  = 6'b100110;
	localparam logic [5:0] fnNor  = 6'b100111;
	localparam logic [5:0] fnSlt  = 6'b101010;         // Signed compare
	localparam logic [5:0] fnSltu = 6'b101011;         // Unsigned compare
	localparam logic [5:0] fnSll  = 6'b000000;
	localparam logic [5:0] fnSrl  = 6'b000010;
	localparam logic [5:0] fnSra  = 6'b000011;
	localparam logic [5:0] fnLui  = 6'b111111;         // ALU-internal only

	// Where the ALU takes its operation from
	typedef enum logic [2:0] {
		selAdd, selFunct, selSlt, selSltu, selAnd, selOr, selXor, selLui
	} aluSelT;

	// One word, two field layouts
	typedef union packed {
		struct packed {
			logic [5:0]              opcode;
			logic [regAddrWidth-1:0] rs;
			logic [regAddrWidth-1:0] rt;
			logic [regAddrWidth-1:0] rd;
			logic [4:0]              shamt;
			logic [5:0]              funct;
		} rFmt;
		struct packed {
			logic [5:0]              opcode;
			logic [regAddrWidth-1:0] rs;
			logic [regAddrWidth-1:0] rt;
			logic [15:0]             imm;          // Zero-extended
		} iFmt;
	} instrT;

	typedef struct packed {
		logic   regDst;                                // rd instead of rt
		logic   aluSrc;                                // Immediate as operand B
		logic   memToReg;                              // Writeback from memory
		logic   regWrite;
		logic   marLoad;
		logic   mdrLoad;
		logic   irLoad;
		aluSelT aluSel;
	} ctrlT;

	typedef struct packed {
		logic                    valid;                // One-cycle request
		logic                    write;
		logic [memAddrWidth-1:0] addr;
		logic [dataWidth-1:0]    data;
	} memReqT;

	typedef struct packed {
		logic                    valid;                // One-cycle pulse
		logic                    regWrite;
		logic [regAddrWidth-1:0] dest;
		logic [dataWidth-1:0]    data;
	} retireT;

endpackage

`default_nettype wire

// File: hw/alu.sv
// ALU with selector and funct decode, arithmetic, logic, shifts, lui and clo
`timescale 1ns/10ps
`default_nettype none

module alu import mipsPkg::*;
(
	input  wire aluSelT               aluSel,
	input  wire logic [5:0]           funct,
	input  wire logic [dataWidth-1:0] a,
	input  wire logic [dataWidth-1:0] b,
	output logic [dataWidth-1:0]      y
);
	logic [5:0] op;                               // Resolved operation code
	logic [4:0] shamt;
	logic [5:0] cloCount;                         // 0 to 32
	logic       cloStop;

	assign shamt = b[4:0];                        // Low 5 bits only

	// Selector to operation
	always_comb
	begin
		case (aluSel)
			selFunct: op = funct;
			selSlt:   op = fnSlt;
			selSltu:  op = fnSltu;
			selAnd:   op = fnAnd;
			selOr:    op = fnOr;
			selXor:   op = fnXor;
			selLui:   op = fnLui;
			default:  op = fnAdd;
		endcase
	end

	// Count leading ones of a from the MSB down
	always_comb
	begin
		cloCount = '0;
		cloStop  = 1'b0;
		for (int i = dataWidth - 1; i >= 0; i--)
		begin
			if (!a[i])
				cloStop = 1'b1;                         // First zero ends the run
			else if (!cloStop)
				cloCount = cloCount + 6'd1;
		end
	end

	always_comb
	begin
		case (op)
			fnAdd:   y = a + b;
			fnSub:   y = a - b;
			fnAnd:   y = a & b;
			fnOr:    y = a | b;
			fnXor:   y = a ^ b;
			fnNor:   y = ~(a | b);
			fnSlt:   y = {31'd0, $signed(a) < $signed(b)};
			fnSltu:  y = {31'd0, a < b};
			fnSll:   y = a << shamt;
			fnSrl:   y = a >> shamt;
			fnSra:   y = $signed(a) >>> shamt;      // Sign fill
			fnClo:   y = {26'd0, cloCount};
			fnLui:   y = (aluSel == selLui) ? {b[15:0], 16'h0000} : '0; // Lui selector only
			default: y = '0;                        // Unknown funct
		endcase
	end

endmodule

`default_nettype wire

// File: hw/registerFile.sv
// 32-entry register file, registered reads, r0 reads zero
`timescale 1ns/10ps
`default_nettype none

module registerFile import mipsPkg::*;
(
	input  wire logic                    clock,
	input  wire logic                    rstN,
	input  wire logic [regAddrWidth-1:0] rsAddr,
	input  wire logic [regAddrWidth-1:0] rtAddr,
	input  wire logic                    wrEn,
	input  wire logic [regAddrWidth-1:0] wrAddr,
	input  wire logic [dataWidth-1:0]    wrData,
	output logic [dataWidth-1:0]         rsData,
	output logic [dataWidth-1:0]         rtData
);
	logic [dataWidth-1:0] regs [2**regAddrWidth];

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < 2**regAddrWidth; i++)
				regs[i] <= '0;                          // All registers read zero
			rsData <= '0;
			rtData <= '0;
		end
		else
		begin
			if (wrEn && (wrAddr != '0))
				regs[wrAddr] <= wrData;                 // r0 stays zero
			rsData <= regs[rsAddr];
			rtData <= regs[rtAddr];
		end
	end

endmodule

`default_nettype wire

// File: hw/datapath.sv
// Datapath: IR, zero-extend, operand and destination muxes, MAR and MDR
// Register file and ALU instances, writeback select
`timescale 1ns/10ps
`default_nettype none

module datapath import mipsPkg::*;
(
	input  wire logic                 clock,
	input  wire logic                 rstN,
	input  wire instrT                instr,
	input  wire ctrlT                 ctrl,
	input  wire logic [dataWidth-1:0] memRdata,
	output logic [5:0]                opcode,
	output logic [memAddrWidth-1:0]   memAddr,
	output logic [dataWidth-1:0]      memWdata,
	output logic [regAddrWidth-1:0]   dest,
	output logic [dataWidth-1:0]      data
);
	instrT                ir;                     // Instruction register
	logic [dataWidth-1:0] rsData;
	logic [dataWidth-1:0] rtData;
	logic [dataWidth-1:0] immExt;
	logic [dataWidth-1:0] opB;
	logic [dataWidth-1:0] aluY;

	//////////////////////////////////////////////////////////////////////
	// Instruction, address and data registers
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
			ir <= '0;                                 // Opcode feeds the FSM
		else if (ctrl.irLoad)
			ir <= instr;
	end

	always_ff @(posedge clock)
	begin
		if (ctrl.marLoad)
			memAddr <= aluY[memAddrWidth-1:0];        // Low bits, wraps
		if (ctrl.mdrLoad)
			memWdata <= rtData;
	end

	assign opcode = ir.rFmt.opcode;
	assign immExt = {16'h0000, ir.iFmt.imm};      // Always zero-extended
	assign opB    = ctrl.aluSrc ? immExt : rtData;
	assign dest   = ctrl.regDst ? ir.rFmt.rd : ir.iFmt.rt;
	assign data   = ctrl.memToReg ? memRdata : aluY; // Writeback value

	registerFile rfInst (
		.clock  (clock),
		.rstN   (rstN),
		.rsAddr (ir.rFmt.rs),
		.rtAddr (ir.rFmt.rt),
		.wrEn   (ctrl.regWrite),
		.wrAddr (dest),
		.wrData (data),
		.rsData (rsData),
		.rtData (rtData)
	);

	alu aluInst (
		.aluSel (ctrl.aluSel),
		.funct  (ir.rFmt.funct),
		.a      (rsData),
		.b      (opB),
		.y      (aluY)
	);

endmodule

`default_nettype wire

// File: hw/controlUnit.sv
// Multicycle FSM: state register, next-state logic, per-state control word
// Also drives the instruction, memory and retire handshakes
`timescale 1ns/10ps
`default_nettype none

module controlUnit import mipsPkg::*;
(
	input  wire logic       clock,
	input  wire logic       rstN,
	input  wire logic       instrValid,
	input  wire logic [5:0] opcode,
	input  wire logic       memDone,
	output logic            instrReady,
	output ctrlT            ctrl,
	output logic            memValid,
	output logic            memWrite,
	output logic            retireValid
);
	typedef enum logic [2:0] {
		sIdle, sDecode, sExec, sAddr, sReq, sWait, sMemRetire
	} stateT;

	stateT  state;
	stateT  nextState;
	aluSelT execSel;                              // Operation for execute
	logic   execKnown;                            // Opcode writes a register
	logic   isMem;

	assign isMem = (opcode == opLw) || (opcode == opSw);

	//////////////////////////////////////////////////////////////////////
	// State register and next state
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
			state <= sIdle;
		else
			state <= nextState;
	end

	always_comb
	begin
		nextState = state;                          // Hold by default
		case (state)
			sIdle:
				if (instrValid)
					nextState = sDecode;                // Accepted
			sDecode:    nextState = isMem ? sAddr : sExec;
			sExec:      nextState = sIdle;
			sAddr:      nextState = sReq;
			sReq:       nextState = sWait;
			sWait:
				if (memDone)
					nextState = sMemRetire;             // No fixed latency assumed
			sMemRetire: nextState = sIdle;
			default:    nextState = sIdle;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Execute decode per opcode
	//////////////////////////////////////////////////////////////////////
	always_comb
	begin
		execKnown = 1'b1;
		case (opcode)
			opR:             execSel = selFunct;
			opAddi, opAddiu: execSel = selAdd;
			opSlti:          execSel = selSlt;
			opSltiu:         execSel = selSltu;
			opAndi:          execSel = selAnd;
			opOri:           execSel = selOr;
			opXori:          execSel = selXor;
			opLui:           execSel = selLui;
			default:
			begin
				execSel   = selAdd;
				execKnown = 1'b0;                       // Retires with no write
			end
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Control word per state
	//////////////////////////////////////////////////////////////////////
	always_comb
	begin
		ctrl        = '0;
		instrReady  = 1'b0;
		memValid    = 1'b0;
		memWrite    = 1'b0;
		retireValid = 1'b0;
		case (state)
			sIdle:
			begin
				instrReady  = 1'b1;
				ctrl.irLoad = instrValid;               // Capture on acceptance
			end
			sExec:
			begin
				ctrl.aluSel   = execSel;
				ctrl.aluSrc   = (opcode != opR);
				ctrl.regDst   = (opcode == opR);
				ctrl.regWrite = execKnown;
				retireValid   = 1'b1;
			end
			sAddr:
			begin
				ctrl.aluSrc  = 1'b1;                    // Base plus offset
				ctrl.marLoad = 1'b1;
				ctrl.mdrLoad = 1'b1;                    // Store data from rt
			end
			sReq:
			begin
				memValid = 1'b1;                        // Single-cycle request
				memWrite = (opcode == opSw);
			end
			sMemRetire:
			begin
				ctrl.memToReg = 1'b1;
				ctrl.regWrite = (opcode == opLw);       // Stores write nothing
				retireValid   = 1'b1;
			end
			default:
			begin
				ctrl = '0;                              // Decode and wait are quiet
			end
		endcase
	end

endmodule

`default_nettype wire

// File: hw/dataMemory.sv
// 512-byte big-endian data memory with request/done handshake
`timescale 1ns/10ps
`default_nettype none

module dataMemory import mipsPkg::*;
(
	input  wire logic             clock,
	input  wire logic             rstN,
	input  wire memReqT           req,
	output logic                  memDone,
	output logic [dataWidth-1:0]  memRdata
);
	logic [7:0]              mem [memBytes];      // No reset on contents
	logic [memAddrWidth-1:0] addr1;
	logic [memAddrWidth-1:0] addr2;
	logic [memAddrWidth-1:0] addr3;
	logic                    doneQ;               // First done stage

	// Byte lanes wrap modulo the memory size
	assign addr1 = req.addr + memAddrWidth'(1);
	assign addr2 = req.addr + memAddrWidth'(2);
	assign addr3 = req.addr + memAddrWidth'(3);

	always_ff @(posedge clock)
	begin
		if (req.valid && req.write)
		begin
			mem[req.addr] <= req.data[31:24];         // MSB at lowest address
			mem[addr1]    <= req.data[23:16];
			mem[addr2]    <= req.data[15:8];
			mem[addr3]    <= req.data[7:0];
		end
		else if (req.valid)
			memRdata <= {mem[req.addr], mem[addr1], mem[addr2], mem[addr3]}; // Held to writeback
	end

	// Done two cycles after the request
	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			doneQ   <= 1'b0;
			memDone <= 1'b0;
		end
		else
		begin
			doneQ   <= req.valid;
			memDone <= doneQ;
		end
	end

endmodule

`default_nettype wire

// File: hw/mipsCore.sv
// Core top level: controller, datapath and data memory
`timescale 1ns/10ps
`default_nettype none

module mipsCore import mipsPkg::*;
(
	input  wire logic  clock,
	input  wire logic  rstN,
	input  wire instrT instr,
	input  wire logic  instrValid,
	output logic       instrReady,
	output retireT     retire
);
	ctrlT                    ctrl;           // Control word to datapath
	memReqT                  memReq;
	logic [5:0]              opcode;         // From instruction register
	logic                    memValid;
	logic                    memWrite;
	logic                    memDone;
	logic                    retireValid;
	logic [memAddrWidth-1:0] memAddr;        // MAR
	logic [dataWidth-1:0]    memWdata;       // MDR
	logic [dataWidth-1:0]    memRdata;
	logic [regAddrWidth-1:0] wbDest;
	logic [dataWidth-1:0]    wbData;

	// Handshake bits from the FSM, payload from the datapath registers
	assign memReq = '{valid: memValid, write: memWrite, addr: memAddr, data: memWdata};
	assign retire = '{valid: retireValid, regWrite: ctrl.regWrite, dest: wbDest, data: wbData};

	controlUnit ctrlInst (
		.clock       (clock),
		.rstN        (rstN),
		.instrValid  (instrValid),
		.opcode      (opcode),
		.memDone     (memDone),
		.instrReady  (instrReady),
		.ctrl        (ctrl),
		.memValid    (memValid),
		.memWrite    (memWrite),
		.retireValid (retireValid)
	);

	datapath dpInst (
		.clock    (clock),
		.rstN     (rstN),
		.instr    (instr),
		.ctrl     (ctrl),
		.memRdata (memRdata),
		.opcode   (opcode),
		.memAddr  (memAddr),
		.memWdata (memWdata),
		.dest     (wbDest),
		.data     (wbData)
	);

	dataMemory memInst (
		.clock    (clock),
		.rstN     (rstN),
		.req      (memReq),
		.memDone  (memDone),
		.memRdata (memRdata)
	);

endmodule

`default_nettype wire

// File: bench/mipsCore_chk.sv
// Bound assertions: ready/retire exclusion, memory done timing, retire pulse width
`timescale 1ns/10ps
`default_nettype none

module mipsCore_chk import mipsPkg::*;
(
	input wire logic   clock,
	input wire logic   rstN,
	input wire logic   instrReady,
	input wire retireT retire,
	input wire memReqT memReq,
	input wire logic   memDone
);
	int assertFails = 0;                          // Failed assertion count

	readyRetireExcl: assert property (@(posedge clock) disable iff (!rstN)
		!(instrReady && retire.valid))
	else
	begin
		$error("instrReady and retire.valid high in the same cycle");
		assertFails++;
	end

	doneAfterReq: assert property (@(posedge clock) disable iff (!rstN)
		memReq.valid |-> ##2 memDone)               // Fixed two-cycle answer
	else
	begin
		$error("memDone did not follow the request by two cycles");
		assertFails++;
	end

	retirePulse: assert property (@(posedge clock) disable iff (!rstN)
		retire.valid |=> !retire.valid)
	else
	begin
		$error("retire.valid held for more than one cycle");
		assertFails++;
	end

endmodule

bind mipsCore mipsCore_chk chkInst (
	.clock      (clock),
	.rstN       (rstN),
	.instrReady (instrReady),
	.retire     (retire),
	.memReq     (memReq),
	.memDone    (memDone)
);

`default_nettype wire

// File: bench/mipsCoreTb.sv
// Testbench top with clock, reset, instruction driver, register and memory model
// Directed tests for reset, immediates, R-type, shifts, memory and register 0
`timescale 1ns/10ps
`default_nettype none

module mipsCoreTb import mipsPkg::*;
();
	logic        clock;
	logic        rstN;
	instrT       instrIn;
	logic        instrValid;
	logic        instrReady;
	retireT      retireOut;

	logic [31:0] refRegs [32];                    // Expected register contents
	logic [7:0]  refMem [512];                    // Expected memory bytes
	retireT      seenRetire;                      // Captured in the retire cycle
	int          seenLatency;                     // Cycles from acceptance to retire
	int          waitLimit;
	int          checkCount;
	int          errorCount;
	int          timeoutCount;

	mipsCore uut (
		.clock      (clock),
		.rstN       (rstN),
		.instr      (instrIn),
		.instrValid (instrValid),
		.instrReady (instrReady),
		.retire     (retireOut)
	);

	always #4 clock = ~clock;                     // 8 ns period

	//////////////////////////////////////////////////////////////////////
	// Checking and run control
	//////////////////////////////////////////////////////////////////////
	task automatic check(input string testName, input logic [31:0] expected,
		input logic [31:0] actual);
		checkCount++;
		if (expected !== actual)
		begin
			errorCount++;
			$display("Mismatch in %s: expected %h, actual %h", testName, expected, actual);
		end
	endtask

	task automatic endRun();
		int assertFails;
		assertFails = uut.chkInst.assertFails;
		$display("Checks %0d, mismatches %0d, timeouts %0d, assertion failures %0d",
			checkCount, errorCount, timeoutCount, assertFails);
		if (errorCount == 0 && timeoutCount == 0 && assertFails == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Instruction encoding and reference model
	//////////////////////////////////////////////////////////////////////
	function automatic logic [31:0] rFormat(input logic [4:0] rd, input logic [4:0] rs,
		input logic [4:0] rt, input logic [5:0] funct);
		return {opR, rs, rt, rd, 5'd0, funct};
	endfunction

	function automatic logic [31:0] iFormat(input logic [5:0] op, input logic [4:0] rt,
		input logic [4:0] rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [4:0] randReg();
		return 5'($urandom_range(31, 1));            // Never r0
	endfunction

	// R-type result with the shift amount from rt instead of shamt
	function automatic logic [31:0] rResult(input logic [5:0] funct, input logic [31:0] a,
		input logic [31:0] b);
		logic [31:0] res;
		int          ones;
		res  = 32'h0;                                 // Unknown funct
		ones = 0;
		case (funct)
			fnAdd:  res = a + b;
			fnSub:  res = a - b;
			fnAnd:  res = a & b;
			fnOr:   res = a | b;
			fnXor:  res = a ^ b;
			fnNor:  res = ~(a | b);
			fnSlt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			fnSltu: res = (a < b) ? 32'd1 : 32'd0;
			fnSll:  res = a << b[4:0];
			fnSrl:  res = a >> b[4:0];
			fnSra:  res = $signed(a) >>> b[4:0];
			fnClo:
			begin
				while (ones < 32 && a[31 - ones])
					ones++;
				res = 32'(ones);
			end
			default: res = 32'h0;
		endcase
		return res;
	endfunction

	task automatic predict(input logic [31:0] word, output logic wr, output logic [4:0] dst,
		output logic [31:0] val);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [8:0]  addr;
		a    = refRegs[word[25:21]];
		b    = refRegs[word[20:16]];
		imm  = {16'h0000, word[15:0]};             // Zero-extended always
		addr = a[8:0] + imm[8:0];                  // Wraps at 512
		wr   = 1'b1;
		dst  = word[20:16];
		val  = 32'h0;
		case (word[31:26])
			opR:
			begin
				dst = word[15:11];
				val = rResult(word[5:0], a, b);
			end
			opAddi, opAddiu: val = a + imm;
			opSlti:  val = ($signed(a) < $signed(imm)) ? 32'd1 : 32'd0;
			opSltiu: val = (a < imm) ? 32'd1 : 32'd0;
			opAndi:  val = a & imm;
			opOri:   val = a | imm;
			opXori:  val = a ^ imm;
			opLui:   val = {word[15:0], 16'h0000};
			opLw:    val = {refMem[addr], refMem[addr + 9'd1], refMem[addr + 9'd2],
				refMem[addr + 9'd3]};                   // Big-endian
			default: wr = 1'b0;                        // Stores and unknown opcodes
		endcase
	endtask

	//////////////////////////////////////////////////////////////////////
	// Driver
	//////////////////////////////////////////////////////////////////////
	// Called and returns on a falling edge
	task automatic issueInstr(input string testName, input logic [31:0] word);
		int waited;
		waited = 0;
		while (!instrReady && waited < waitLimit)
		begin
			@(negedge clock);
			waited++;
		end
		if (!instrReady)
		begin
			timeoutCount++;
			$display("Timeout in %s: the core never became ready for an instruction", testName);
			endRun();
		end
		else
		begin
			instrIn    = word;
			instrValid = 1'b1;
			@(negedge clock);                         // Accepted on the edge just passed
			instrValid  = 1'b0;
			instrIn     = $urandom;                   // IR must hold its copy
			seenLatency = 1;
			while (!retireOut.valid && seenLatency < waitLimit)
			begin
				@(negedge clock);
				seenLatency++;
			end
			if (!retireOut.valid)
			begin
				timeoutCount++;
				$display("Timeout in %s: the instruction never retired", testName);
				endRun();
			end
			else
				seenRetire = retireOut;
		end
	endtask

	task automatic runInstr(input string testName, input logic [31:0] word);
		logic        expWr;
		logic [4:0]  expDst;
		logic [31:0] expVal;
		logic [31:0] stData;
		logic [8:0]  stAddr;
		predict(word, expWr, expDst, expVal);
		stData = refRegs[word[20:16]];
		stAddr = refRegs[word[25:21]][8:0] + word[8:0];
		issueInstr(testName, word);
		check(testName, 32'(expWr), 32'(seenRetire.regWrite));
		if (expWr)
		begin
			check(testName, 32'(expDst), 32'(seenRetire.dest));
			check(testName, expVal, seenRetire.data);
			if (expDst != 5'd0)
				refRegs[expDst] = expVal;                // r0 never changes
		end
		if (word[31:26] != opLw && word[31:26] != opSw)
			check({testName, " latency"}, 32'd2, 32'(seenLatency));
		if (word[31:26] == opSw)
		begin
			refMem[stAddr]         = stData[31:24];
			refMem[stAddr + 9'd1]  = stData[23:16];
			refMem[stAddr + 9'd2]  = stData[15:8];
			refMem[stAddr + 9'd3]  = stData[7:0];
		end
	endtask

	task automatic loadReg(input string testName, input logic [4:0] r, input logic [31:0] v);
		runInstr(testName, iFormat(opLui, r, 5'd0, v[31:16]));
		runInstr(testName, iFormat(opOri, r, r, v[15:0]));
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////
	task automatic testReset();
		int i;
		check("reset ready", 32'd1, 32'(instrReady));
		for (i = 0; i < 6; i++)
		begin
			check("reset idle retire", 32'd0, 32'(retireOut.valid));
			@(negedge clock);
		end
		for (i = 1; i < 32; i++)
			runInstr("reset register", rFormat(5'(i), 5'(i), 5'd0, fnAdd));
	endtask

	task automatic testImmediates();
		logic [5:0] immOps [8];
		int         i;
		immOps = '{opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui};
		runInstr("addi zero-extend", iFormat(opAddi, 5'd3, 5'd0, 16'h8001));
		check("addi zero-extend", 32'h0000_8001, seenRetire.data);
		for (i = 0; i < 32; i++)
			runInstr("immediate", iFormat(immOps[i % 8], randReg(), 5'($urandom_range(31, 0)),
				16'($urandom)));
	endtask

	task automatic testRegisterOps();
		logic [5:0] functs [8];
		int         i;
		functs = '{fnAdd, fnSub, fnAnd, fnOr, fnXor, fnNor, fnSlt, fnSltu};
		for (i = 1; i <= 8; i++)
			loadReg("register setup", 5'(i), $urandom);
		for (i = 0; i < 32; i++)
			runInstr("register op", rFormat(randReg(), 5'($urandom_range(8, 1)),
				5'($urandom_range(8, 1)), functs[i % 8]));
		loadReg("compare setup", 5'd9, 32'h8000_0000);
		loadReg("compare setup", 5'd10, 32'h0000_0001);
		runInstr("slt signed", rFormat(5'd11, 5'd9, 5'd10, fnSlt));
		check("slt signed", 32'd1, seenRetire.data);
		runInstr("sltu unsigned", rFormat(5'd11, 5'd9, 5'd10, fnSltu));
		check("sltu unsigned", 32'd0, seenRetire.data);
	endtask

	task automatic testShifts();
		logic [31:0] cloVals [5];
		logic [31:0] cloExp [5];
		int          i;
		cloVals = '{32'hffff_0000, 32'hffff_ffff, 32'h0000_0000, 32'h7fff_ffff, 32'hfff0_1234};
		cloExp  = '{32'd16, 32'd32, 32'd0, 32'd0, 32'd12};
		loadReg("shift setup", 5'd12, $urandom | 32'h8000_0000);  // Negative for sra
		loadReg("shift setup", 5'd13, 32'hffff_ffe3);             // Low bits give 3
		runInstr("sra by low bits", rFormat(5'd14, 5'd12, 5'd13, fnSra));
		check("sra by low bits", 32'(($signed(refRegs[12]) >>> 3)), seenRetire.data);
		for (i = 0; i < 6; i++)
		begin
			loadReg("shift amount", 5'd13, $urandom);
			runInstr("sll", rFormat(5'd14, 5'd12, 5'd13, fnSll));
			runInstr("srl", rFormat(5'd15, 5'd12, 5'd13, fnSrl));
			runInstr("sra", rFormat(5'd16, 5'd12, 5'd13, fnSra));
			runInstr("lui", iFormat(opLui, randReg(), 5'd0, 16'($urandom)));
		end
		for (i = 0; i < 5; i++)
		begin
			loadReg("clo setup", 5'd17, cloVals[i]);
			runInstr("clo", rFormat(5'd18, 5'd17, 5'd0, fnClo));
			check("clo count", cloExp[i], seenRetire.data);
		end
		runInstr("unknown funct", rFormat(5'd19, 5'd12, 5'd13, 6'b011000));
		check("unknown funct", 32'h0, seenRetire.data);
		runInstr("unused funct ones", rFormat(5'd20, 5'd12, 5'd13, 6'b111111));
		check("unused funct ones", 32'h0, seenRetire.data);
	endtask

	task automatic testMemory();
		logic [31:0] d1;
		logic [31:0] d2;
		logic [15:0] off;
		int          i;
		for (i = 0; i < 8; i++)
		begin
			d1  = $urandom;
			d2  = $urandom;
			off = 16'($urandom);
			loadReg("memory setup", 5'd2, d1);
			loadReg("memory setup", 5'd3, d2);
			runInstr("memory base", iFormat(opOri, 5'd1, 5'd0, 16'($urandom)));
			runInstr("sw", iFormat(opSw, 5'd2, 5'd1, off));
			runInstr("sw overlap", iFormat(opSw, 5'd3, 5'd1, off + 16'd2));
			runInstr("lw", iFormat(opLw, 5'd4, 5'd1, off));
			check("lw big-endian", {d1[31:16], d2[31:16]}, seenRetire.data);
			runInstr("lw unaligned", iFormat(opLw, 5'd5, 5'd1, off + 16'd1));
			check("lw unaligned", {d1[23:16], d2[31:8]}, seenRetire.data);
			runInstr("lw second", iFormat(opLw, 5'd6, 5'd1, off + 16'd2));
			check("lw second", d2, seenRetire.data);
		end
	endtask

	task automatic testRegZero();
		logic [31:0] keep;
		keep = $urandom;
		loadReg("r0 setup", 5'd1, $urandom);
		loadReg("r0 setup", 5'd7, keep);
		runInstr("write r0", iFormat(opAddi, 5'd0, 5'd1, 16'($urandom)));
		check("write r0 dest", 32'd0, 32'(seenRetire.dest));
		runInstr("write r0", rFormat(5'd0, 5'd1, 5'd7, fnSub));
		runInstr("read r0", rFormat(5'd5, 5'd0, 5'd0, fnAdd));
		check("read r0", 32'd0, seenRetire.data);
		runInstr("read r0", rFormat(5'd6, 5'd0, 5'd1, fnOr));
		runInstr("unknown opcode", iFormat(6'b000010, 5'd7, 5'd1, 16'($urandom)));
		runInstr("unknown opcode", iFormat(6'b000100, 5'd7, 5'd1, 16'($urandom)));
		runInstr("after unknown", rFormat(5'd8, 5'd7, 5'd0, fnAdd));
		check("after unknown", keep, seenRetire.data);
	endtask

	initial
	begin
		void'($urandom(32'h3f251a6d));            // Seed once
		waitLimit    = 64;
		checkCount   = 0;
		errorCount   = 0;
		timeoutCount = 0;
		clock        = 1'b0;
		rstN         = 1'b0;
		instrIn      = '0;
		instrValid   = 1'b0;
		for (int i = 0; i < 32; i++)
			refRegs[i] = 32'h0;
		repeat (16) @(posedge clock);
		@(negedge clock);
		rstN = 1'b1;
		testReset();
		testImmediates();
		testRegisterOps();
		testShifts();
		testMemory();
		testRegZero();
		endRun();
	end

endmodule

`default_nettype wire

// File: mipsCore.f
hw/mipsPkg.sv
hw/alu.sv
hw/registerFile.sv
hw/datapath.sv
hw/controlUnit.sv
hw/dataMemory.sv
hw/mipsCore.sv
bench/mipsCore_chk.sv
bench/mipsCoreTb.sv
